//--- adder_pkg.sv
package adder_pkg;

	// --------------------
	// datapath sizes
	// --------------------

	// operand and sum width
	localparam int WIDTH = 32;

	// prefix rows, spans 1, 2, 4, 8, 16
	localparam int LEVELS = 5;

	// --------------------
	// flow control
	// --------------------

	// buffer slots, also the producer's starting credits
	localparam int BUF_DEPTH = 4;

	// results the sink can take before returning credits
	localparam int OUT_CREDITS = 2;

	// credit counter width, holds up to 7
	localparam int CNT_W = 3;

	// --------------------
	// payloads
	// --------------------

	typedef logic [WIDTH-1:0] word_t;

	// generate word, propagate word and carry-in, 65 bits
	typedef struct packed {
		word_t g;
		word_t p;
		logic  cin;
	} pg_word_t;

endpackage

//--- pg_stage.sv
`timescale 1ns/1ps

module pg_stage import adder_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  word_t    a,
	input  word_t    b,
	input  logic     cin,
	input  logic     credit_return,
	output logic     in_ready,
	output logic     push,
	output pg_word_t push_data
);

	// one credit per free buffer slot
	logic [CNT_W-1:0] credits;
	logic             accept;

	assign in_ready = (credits != '0);
	assign accept   = in_valid & in_ready;

	// --------------------
	// buffer credits
	// --------------------

	// spend on accept, regain on credit_return, both may happen together
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CNT_W'(BUF_DEPTH);
		end else begin
			case ({accept, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// --------------------
	// push toward buffer
	// --------------------

	// push follows acceptance by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			push <= 1'b0;
		end else begin
			push <= accept;
		end
	end

	// per-bit generate and propagate
	// propagate as xor so the sum stage can reuse it
	always_ff @(posedge clk) begin
		if (accept) begin
			push_data.g   <= a & b;
			push_data.p   <= a ^ b;
			push_data.cin <= cin;
		end
	end

endmodule

//--- credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo import adder_pkg::*; #(
	parameter int DEPTH = BUF_DEPTH
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  pg_word_t push_data,
	input  logic     pop,
	output logic     not_empty,
	output pg_word_t head,
	output logic     credit_return
);

	localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);

	pg_word_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [COUNT_W-1:0] count;
	logic               do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign not_empty = (count != '0);
	assign head      = mem[rd_ptr];

	// an empty pop is ignored and returns nothing
	assign do_pop        = pop & not_empty;
	assign credit_return = do_pop;

	// --------------------
	// storage
	// --------------------

	// no full check, the producer never pushes without a credit
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// --------------------
	// pointers and occupancy
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- kogge_stone_tree.sv
`timescale 1ns/1ps

module kogge_stone_tree import adder_pkg::*; (
	input  pg_word_t pg,
	output word_t    carry
);

	// running group generate and propagate, updated row by row
	word_t g_acc;
	word_t p_acc;

	always_comb begin
		g_acc = pg.g;
		p_acc = pg.p;

		// carry-in folded into bit 0, so group g down to bit 0 is the carry
		g_acc[0] = pg.g[0] | (pg.p[0] & pg.cin);

		// row k combines each bit with the group 2^k below it
		for (int k = 0; k < LEVELS; k++) begin
			// walk downward so the low side still holds last row's value
			for (int i = WIDTH - 1; i >= (1 << k); i--) begin
				g_acc[i] = g_acc[i] | (p_acc[i] & g_acc[i - (1 << k)]);
				// last row's propagate has no consumer
				if (k < LEVELS - 1) begin
					p_acc[i] = p_acc[i] & p_acc[i - (1 << k)];
				end
			end
			// bits below 2^k are complete and pass through
		end

		carry = g_acc;
	end

endmodule

//--- sum_stage.sv
`timescale 1ns/1ps

module sum_stage import adder_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     not_empty,
	input  pg_word_t head,
	input  logic     out_credit,
	output logic     pop,
	output logic     out_valid,
	output word_t    sum,
	output logic     cout
);

	logic [CNT_W-1:0] credits;
	word_t            carry;

	kogge_stone_tree tree_i (
		.pg    (head),
		.carry (carry)
	);

	// take the head only when the sink has room for the result
	assign pop = not_empty & (credits != '0);

	// --------------------
	// output credits
	// --------------------

	// a pop commits one result, so the credit goes there
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CNT_W'(OUT_CREDITS);
		end else begin
			case ({pop, out_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// --------------------
	// result register
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop;
		end
	end

	// carry into bit i is carry[i-1], carry-in feeds bit 0
	always_ff @(posedge clk) begin
		if (pop) begin
			sum  <= head.p ^ {carry[WIDTH-2:0], head.cin};
			cout <= carry[WIDTH-1];
		end
	end

endmodule

//--- ks_adder_top.sv
`timescale 1ns/1ps

module ks_adder_top import adder_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  word_t a,
	input  word_t b,
	input  logic  cin,
	input  logic  out_credit,
	output logic  in_ready,
	output logic  out_valid,
	output word_t sum,
	output logic  cout
);

	// producer to buffer
	logic     push;
	pg_word_t push_data;
	logic     credit_return;

	// buffer to consumer
	logic     not_empty;
	pg_word_t head;
	logic     pop;

	pg_stage pg_stage_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.a             (a),
		.b             (b),
		.cin           (cin),
		.credit_return (credit_return),
		.in_ready      (in_ready),
		.push          (push),
		.push_data     (push_data)
	);

	// depth matches the producer's starting credits
	credit_fifo #(
		.DEPTH (BUF_DEPTH)
	) credit_fifo_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.push          (push),
		.push_data     (push_data),
		.pop           (pop),
		.not_empty     (not_empty),
		.head          (head),
		.credit_return (credit_return)
	);

	sum_stage sum_stage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.not_empty  (not_empty),
		.head       (head),
		.out_credit (out_credit),
		.pop        (pop),
		.out_valid  (out_valid),
		.sum        (sum),
		.cout       (cout)
	);

endmodule

//--- ks_adder_props.sv
`timescale 1ns/1ps

module ks_adder_props import adder_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic push,
	input logic pop,
	input logic not_empty,
	input logic out_valid,
	input logic out_credit
);

	// buffer fill and output credit traffic counted beside the DUT
	int occupancy;
	int outputs;
	int returned;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			occupancy <= 0;
			outputs   <= 0;
			returned  <= 0;
		end else begin
			occupancy <= occupancy + int'(push) - int'(pop);
			if (out_valid) begin
				outputs <= outputs + 1;
			end
			if (out_credit) begin
				returned <= returned + 1;
			end
		end
	end

	// --------------------
	// reset
	// --------------------

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid is high while reset is asserted");

	reset_exit: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid is high on the first edge after reset");

	// --------------------
	// flow control
	// --------------------

	occupancy_bound: assert property (@(posedge clk) disable iff (!rst_n)
		occupancy <= BUF_DEPTH)
		else $error("buffer holds more words than it has slots");

	empty_flag: assert property (@(posedge clk) disable iff (!rst_n)
		not_empty == (occupancy != 0))
		else $error("not_empty disagrees with the number of words in the buffer");

	pop_guard: assert property (@(posedge clk) disable iff (!rst_n) pop |-> occupancy != 0)
		else $error("pop while the buffer is empty");

	// results sent so far including this one
	output_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		outputs + int'(out_valid) <= OUT_CREDITS + returned)
		else $error("more results sent than output credits allow");

endmodule

//--- tb_ks_adder.sv
`timescale 1ns/1ps

module tb_ks_adder import adder_pkg::*; ();

	localparam int RANDOM_OPS      = 200;
	localparam int CORNER_OPS      = 4;
	localparam int THROTTLE_OPS    = 100;
	localparam int TOTAL_OPS       = RANDOM_OPS + CORNER_OPS + BUF_DEPTH + OUT_CREDITS
		+ THROTTLE_OPS;
	localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 200;

	// how the sink hands back output credits
	localparam int SINK_HOLD   = 0;
	localparam int SINK_EVERY  = 1;
	localparam int SINK_RANDOM = 2;

	logic  clk;
	logic  rst_n;
	logic  in_valid;
	word_t a;
	word_t b;
	logic  cin;
	logic  out_credit;
	logic  in_ready;
	logic  out_valid;
	word_t sum;
	logic  cout;

	logic [WIDTH:0] expected_q [$];
	string          test_name;
	int             sink_mode;
	int             owed;
	logic           give;
	logic [31:0]    stim_lfsr = 32'd2;
	logic [31:0]    sink_lfsr = 32'd2;

	ks_adder_top ks_adder_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.a          (a),
		.b          (b),
		.cin        (cin),
		.out_credit (out_credit),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.sum        (sum),
		.cout       (cout)
	);

	bind ks_adder_top ks_adder_props props_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (push),
		.pop        (pop),
		.not_empty  (not_empty),
		.out_valid  (out_valid),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------

	// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	function automatic logic rand_bit();
		stim_lfsr = lfsr_step(stim_lfsr);
		return stim_lfsr[0];
	endfunction

	function automatic word_t rand_word();
		word_t value;
		value = '0;
		for (int i = 0; i < WIDTH; i++) begin
			value = {value[WIDTH-2:0], rand_bit()};
		end
		return value;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic drive_operands(input word_t op_a, input word_t op_b, input logic op_cin);
		in_valid <= 1'b1;
		a        <= op_a;
		b        <= op_b;
		cin      <= op_cin;
	endtask

	// starts just after a rising edge and returns on the accepting edge
	task automatic send_op(input word_t op_a, input word_t op_b, input logic op_cin);
		drive_operands(op_a, op_b, op_cin);
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0) begin
			@(posedge clk);
		end
		// sink returns its last credits
		repeat (4) @(posedge clk);
	endtask

	task automatic check_result();
		logic [WIDTH:0] expected;
		if (expected_q.size() == 0) begin
			stop_with_failure($sformatf("a result came out in test %s with no operand pending",
				test_name));
		end else begin
			expected = expected_q.pop_front();
			assert ({cout, sum} === expected) else begin
				stop_with_failure($sformatf(
					"CHECK FAILED %s expected sum %h cout %b actual sum %h cout %b",
					test_name, expected[WIDTH-1:0], expected[WIDTH], sum, cout));
			end
		end
	endtask

	// --------------------
	// monitor and sink
	// --------------------

	// sampled mid-cycle so an accept here completes on the next rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (in_valid && in_ready) begin
				expected_q.push_back({1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, cin});
			end
			if (out_valid) begin
				check_result();
			end
		end
	end

	// one credit back per result taken
	initial begin
		out_credit = 1'b0;
		owed = 0;
		forever begin
			@(posedge clk);
			if (out_valid) begin
				owed++;
			end
			give = 1'b0;
			if (owed > 0) begin
				if (sink_mode == SINK_EVERY) begin
					give = 1'b1;
				end else if (sink_mode == SINK_RANDOM) begin
					sink_lfsr = lfsr_step(sink_lfsr);
					give = sink_lfsr[0];
				end
			end
			if (give) begin
				owed--;
			end
			out_credit <= give;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_failure("timeout, the tests did not complete within the cycle budget");
	end

	// --------------------
	// test sequence
	// --------------------

	initial begin
		int    accepted;
		logic  took;
		word_t op_a;
		word_t op_b;
		logic  op_cin;

		rst_n     = 1'b0;
		in_valid  = 1'b0;
		a         = '0;
		b         = '0;
		cin       = 1'b0;
		sink_mode = SINK_EVERY;
		test_name = "reset";
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (in_ready === 1'b1 && out_valid === 1'b0) else begin
			stop_with_failure($sformatf(
				"CHECK FAILED %s expected in_ready 1 out_valid 0 actual in_ready %b out_valid %b",
				test_name, in_ready, out_valid));
		end
		@(posedge clk);

		test_name = "random";
		for (int i = 0; i < RANDOM_OPS; i++) begin
			op_a   = rand_word();
			op_b   = rand_word();
			op_cin = rand_bit();
			send_op(op_a, op_b, op_cin);
		end
		wait_drain();

		test_name = "carry_chain";
		send_op(32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
		send_op(32'h5555_5555, 32'hAAAA_AAAA, 1'b0);
		send_op(32'h5555_5555, 32'hAAAA_AAAA, 1'b1);
		send_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1);
		wait_drain();

		// with the sink stalled only buffer slots and output credits absorb operands
		test_name = "back_pressure";
		sink_mode <= SINK_HOLD;
		accepted = 0;
		op_a   = rand_word();
		op_b   = rand_word();
		op_cin = rand_bit();
		drive_operands(op_a, op_b, op_cin);
		for (int c = 0; c < 20; c++) begin
			@(negedge clk);
			took = in_ready;
			@(posedge clk);
			if (took) begin
				accepted++;
				op_a   = rand_word();
				op_b   = rand_word();
				op_cin = rand_bit();
				drive_operands(op_a, op_b, op_cin);
			end
		end
		in_valid <= 1'b0;
		@(negedge clk);
		assert (accepted == BUF_DEPTH + OUT_CREDITS && in_ready === 1'b0) else begin
			stop_with_failure($sformatf(
				"CHECK FAILED %s expected accepted %0d in_ready 0 actual accepted %0d in_ready %b",
				test_name, BUF_DEPTH + OUT_CREDITS, accepted, in_ready));
		end
		@(posedge clk);
		sink_mode <= SINK_EVERY;
		wait_drain();

		test_name = "throttled";
		sink_mode <= SINK_RANDOM;
		for (int i = 0; i < THROTTLE_OPS; i++) begin
			while (rand_bit()) begin
				@(posedge clk);
			end
			op_a   = rand_word();
			op_b   = rand_word();
			op_cin = rand_bit();
			send_op(op_a, op_b, op_cin);
		end
		wait_drain();

		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- vlog.f
adder_pkg.sv
pg_stage.sv
credit_fifo.sv
kogge_stone_tree.sv
sum_stage.sv
ks_adder_top.sv
ks_adder_props.sv
tb_ks_adder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the adder testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_ks_adder \
	-Mdir obj_dir \
	-f vlog.f

# a failing run still leaves its log for the search below
./obj_dir/Vtb_ks_adder > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "NO ERRORS" "$LOG"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
